//--- lua_cpu.f
+incdir+src
src/lua_isa_pkg.sv
src/cpu_ctrl_pkg.sv
src/cpu_ifs.sv
src/host_cmd.sv
src/fetch_unit.sv
src/exec_sequencer.sv
src/reg_bank.sv
src/frame_store.sv
src/lua_cpu.sv
dv/lua_mem_model.sv
dv/tb_lua_cpu.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_lua_cpu -f lua_cpu.f -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed"
	exit $status
fi

./obj_dir/Vtb_lua_cpu
status=$?
if [ $status -ne 0 ]; then
	echo "simulation failed"
fi
exit $status

//--- dv/tb_lua_cpu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_lua_cpu;
	localparam logic [`WORD_W-1:0] ci_addr = 32'h100;
	localparam logic [`WORD_W-1:0] base_addr = 32'h800;
	localparam logic [`WORD_W-1:0] prog_addr = 32'h200;
	localparam int k_first = 6;
	localparam int k_second = 11;
	localparam int load_cnt = 2 * `REG_CNT + 3;
	localparam int bus_xfers = k_first + k_second + 2 * (3 + 2 * `REG_CNT);
	localparam int cycle_limit = 4 * (16 + 4 * load_cnt + 2 * bus_xfers);

	logic               clk;
	logic               rst;
	logic               start;
	logic [1:0]         n;
	logic [`WORD_W-1:0] dataa;
	logic [`WORD_W-1:0] datab;
	logic [`WORD_W-1:0] result;
	logic [`WORD_W-1:0] address;
	logic [`WORD_W-1:0] writedata;
	logic [`WORD_W-1:0] readdata;
	logic               done;
	logic               read;
	logic               write;
	logic               waitrequest;
	logic [`WORD_W-1:0] exp_val [`REG_CNT];
	logic [`TTAG_W-1:0] exp_tag [`REG_CNT];
	logic [`WORD_W-1:0] next_pc;
	int                 cycles = 0;

	lua_cpu i_dut (.clk, .rst, .start, .n, .dataa, .datab, .result, .done, .address,
		.writedata, .read, .write, .readdata, .waitrequest);

	lua_mem_model i_mem (.clk, .rst, .address, .writedata, .read, .write, .readdata,
		.waitrequest);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic report_fail(input string what);
		$display("%s", what);
		$display("** FAIL **");
		$fatal(1, "simulation stopped");
	endtask

	task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
		report_fail($sformatf("Error %s expected %h actual %h", name, exp, act));
	endtask

	task automatic issue_cmd(input logic [1:0] kind, input logic [31:0] a, input logic [31:0] b);
		@(posedge clk);
		start <= 1'b1;
		n <= kind;
		dataa <= a;
		datab <= b;
		@(posedge clk);
		start <= 1'b0;
		do begin
			@(negedge clk);
		end while (!done);
	endtask

	task automatic run_program(input int k, input int salt);
		logic [31:0] pc;
		logic [31:0] add_word;
		int          ra;
		int          rb;
		pc = next_pc;
		for (int j = 0; j < k; j++) begin
			ra = (j * 7 + salt) % `REG_CNT;
			rb = (j * 13 + salt + 5) % `REG_CNT;
			i_mem.mem[pc >> 2] <= {9'h0, 9'(rb), 8'(ra), 6'd0};	// MOVE A B
			exp_val[ra] = exp_val[rb];
			exp_tag[ra] = exp_tag[rb];
			pc += 4;
		end
		add_word = {9'(salt), 9'd3, 8'd2, 6'd13};	// ADD stops the run
		i_mem.mem[pc >> 2] <= add_word;
		next_pc = pc + 4;
		issue_cmd(2'd0, 32'h0, ci_addr);
		assert (i_mem.mem[(ci_addr + 20) >> 2] == next_pc)
			else value_error("saved_pc", next_pc, i_mem.mem[(ci_addr + 20) >> 2]);
		assert (result == add_word) else value_error("result", add_word, result);
		for (int i = 0; i < `REG_CNT; i++) begin
			assert (i_mem.mem[(base_addr + 8 * i) >> 2] == exp_val[i])
				else value_error($sformatf("slot%0d_value", i), exp_val[i],
					i_mem.mem[(base_addr + 8 * i) >> 2]);
			assert (i_mem.mem[(base_addr + 8 * i + 4) >> 2] == 32'(exp_tag[i]))
				else value_error($sformatf("slot%0d_tag", i), 32'(exp_tag[i]),
					i_mem.mem[(base_addr + 8 * i + 4) >> 2]);
		end
	endtask

	a_load_quiet: assert property (@(posedge clk) disable iff (rst)
		$past(start && n != 2'd0) |-> !done && !read && !write)
		else report_fail("done or bus activity one cycle after a load command");
	a_load_done: assert property (@(posedge clk) disable iff (rst)
		$past(start && n != 2'd0, 2) |-> done && !read && !write)
		else report_fail("load command did not raise done two cycles after start");
	a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
		else report_fail("done stayed high for more than one cycle");
	a_read_hold: assert property (@(posedge clk) disable iff (rst)
		read && waitrequest |=> read && $stable(address))
		else report_fail("read dropped or address moved while waitrequest was high");
	a_write_hold: assert property (@(posedge clk) disable iff (rst)
		write && waitrequest |=> write && $stable(address) && $stable(writedata))
		else report_fail("write dropped or address or data moved while waitrequest was high");

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
			report_fail("timeout, the DUT did not finish the tests in time");
	end

	initial begin
		rst = 1'b1;
		start = 1'b0;
		n = 2'd0;
		dataa = '0;
		datab = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		assert (result == '0) else value_error("reset_result", 32'h0, result);
		assert (!done && !read && !write)
			else value_error("reset_strobes", 32'h0, {29'h0, done, read, write});
		i_mem.mem[(ci_addr + 20) >> 2] <= prog_addr;	// saved pc of the frame
		next_pc = prog_addr;
		issue_cmd(2'd3, base_addr, 32'h0);
		for (int i = 0; i < `REG_CNT; i++) begin
			exp_val[i] = 32'h1000_0000 + i * 32'h0101_0011;
			exp_tag[i] = 5'(i) ^ 5'h15;
			issue_cmd(2'd1, base_addr + 8 * i, exp_val[i]);
			issue_cmd(2'd2, base_addr + 8 * i, 32'hffff_ffe0 | 32'(exp_tag[i]));
		end
		run_program(k_first, 1);
		issue_cmd(2'd1, base_addr + 8 * `REG_CNT, 32'hdead_beef);	// index 32
		issue_cmd(2'd2, base_addr - 8, 32'h0000_001f);	// wraps far out of range
		run_program(k_second, 2);
		$display("** PASS **");
		$finish;
	end
endmodule

//--- dv/lua_mem_model.sv
`timescale 1ns/1ps

module lua_mem_model #(
	parameter int depth = 1024
) (
	input  logic        clk,
	input  logic        rst,
	input  logic [31:0] address,
	input  logic [31:0] writedata,
	input  logic        read,
	input  logic        write,
	output logic [31:0] readdata,
	output logic        waitrequest
);
	localparam int aw = $clog2(depth);

	logic [31:0] mem [depth];
	logic [15:0] lfsr;
	logic [15:0] lfsr_next;

	// fibonacci with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	initial begin
		for (int i = 0; i < depth; i++)
			mem[i] = 32'hc0de_0000 ^ 32'(i * 4);	// byte address pattern
	end

	assign lfsr_next = lfsr_step(lfsr);
	assign readdata = read ? mem[address[aw+1:2]] : '0;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			lfsr <= 16'd59;
			waitrequest <= 1'b0;
		end else begin
			lfsr <= lfsr_next;
			waitrequest <= lfsr_next[0];	// one new bit per cycle
		end
	end

	always @(posedge clk) begin
		if (write && !waitrequest && !rst)
			mem[address[aw+1:2]] <= writedata;
	end
endmodule

//--- src/lua_cpu.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module lua_cpu (
	input  logic              clk,
	input  logic              rst,
	input  logic              start,
	input  logic [1:0]        n,
	input  logic [`WORD_W-1:0] dataa,
	input  logic [`WORD_W-1:0] datab,
	output logic [`WORD_W-1:0] result,
	output logic              done,
	output logic [`WORD_W-1:0] address,
	output logic [`WORD_W-1:0] writedata,
	output logic              read,
	output logic              write,
	input  logic [`WORD_W-1:0] readdata,
	input  logic              waitrequest
);
	mem_if       fetch_bus();
	reg_write_if host_wr();

	logic                    cmd_valid;
	cpu_ctrl_pkg::host_cmd_e cmd_kind;
	lua_isa_pkg::word_t      base;
	lua_isa_pkg::word_t      ci;
	logic                    fetch_pc;
	logic                    fetch_instr;
	logic                    store_pc;
	logic                    store_regs;
	logic                    pc_done;
	logic                    ir_done;
	logic                    store_done;
	lua_isa_pkg::instr_t     instr;
	lua_isa_pkg::reg_idx_t   rd_idx_b;
	lua_isa_pkg::reg_idx_t   rd_idx_c;
	lua_isa_pkg::reg_idx_t   wr_idx;
	lua_isa_pkg::word_t      wr_val;
	lua_isa_pkg::ttag_t      wr_tag;
	logic                    wr_val_en;
	logic                    wr_tag_en;
	lua_isa_pkg::word_t      rd_val_b;
	lua_isa_pkg::word_t      rd_val_c;
	lua_isa_pkg::ttag_t      rd_tag_b;
	lua_isa_pkg::ttag_t      rd_tag_c;

	assign result = lua_isa_pkg::word_t'(instr);	// last fetched word

	host_cmd i_host_cmd (.clk, .rst, .start, .n(cpu_ctrl_pkg::host_cmd_e'(n)), .dataa, .datab,
		.cmd_valid, .cmd_kind, .base, .ci, .wr(host_wr));

	fetch_unit i_fetch_unit (.clk, .rst, .ci, .fetch_pc, .fetch_instr, .store_pc,
		.pc_done, .ir_done, .instr, .mem(fetch_bus));

	exec_sequencer i_exec_sequencer (.clk, .rst, .cmd_valid, .cmd_kind, .pc_done, .ir_done,
		.store_done, .instr, .host_wr, .rd_val_b, .rd_tag_b, .fetch_pc, .fetch_instr,
		.store_pc, .store_regs, .rd_idx_b, .wr_idx, .wr_val, .wr_tag, .wr_val_en,
		.wr_tag_en, .done);

	reg_bank #(.entry_t(lua_isa_pkg::word_t)) i_val_bank (.clk, .rst, .wr_idx,
		.wr_data(wr_val), .wr_en(wr_val_en), .rd_idx_b, .rd_idx_c,
		.rd_data_b(rd_val_b), .rd_data_c(rd_val_c));

	reg_bank #(.entry_t(lua_isa_pkg::ttag_t)) i_tag_bank (.clk, .rst, .wr_idx,
		.wr_data(wr_tag), .wr_en(wr_tag_en), .rd_idx_b, .rd_idx_c,
		.rd_data_b(rd_tag_b), .rd_data_c(rd_tag_c));

	frame_store i_frame_store (.clk, .rst, .store_regs, .base, .rd_val_c, .rd_tag_c,
		.fetch_mem(fetch_bus), .rd_idx_c, .store_done, .address, .writedata, .read, .write,
		.readdata, .waitrequest);
endmodule

//--- src/frame_store.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module frame_store (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  store_regs,
	input  lua_isa_pkg::word_t    base,
	input  lua_isa_pkg::word_t    rd_val_c,
	input  lua_isa_pkg::ttag_t    rd_tag_c,
	mem_if.responder              fetch_mem,
	output lua_isa_pkg::reg_idx_t rd_idx_c,
	output logic                  store_done,
	output lua_isa_pkg::word_t    address,
	output lua_isa_pkg::word_t    writedata,
	output logic                  read,
	output logic                  write,
	input  lua_isa_pkg::word_t    readdata,
	input  logic                  waitrequest
);
	logic                  busy;
	logic                  phase;	// 0 value, 1 tag
	lua_isa_pkg::reg_idx_t cnt;
	lua_isa_pkg::word_t    slot_addr;

	assign slot_addr = base + (lua_isa_pkg::word_t'(cnt) << `TVALUE_SHIFT)
		+ (phase ? lua_isa_pkg::word_t'(`TAG_OFFSET) : '0);
	assign rd_idx_c = cnt;

	assign address = busy ? slot_addr : fetch_mem.address;
	assign writedata = busy ? (phase ? lua_isa_pkg::word_t'(rd_tag_c) : rd_val_c)
		: fetch_mem.writedata;
	assign read = !busy && fetch_mem.read;
	assign write = busy || fetch_mem.write;
	assign fetch_mem.readdata = readdata;
	assign fetch_mem.waitrequest = waitrequest || busy;	// stall fetch while storing

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			busy <= 1'b0;
			phase <= 1'b0;
			cnt <= '0;
			store_done <= 1'b0;
		end else begin
			store_done <= 1'b0;
			if (!busy) begin
				if (store_regs && !store_done) begin
					busy <= 1'b1;
					phase <= 1'b0;
					cnt <= '0;
				end
			end else if (!waitrequest) begin
				phase <= !phase;
				if (phase) begin
					cnt <= cnt + 1'b1;
					if (cnt == lua_isa_pkg::reg_idx_t'(`REG_CNT - 1)) begin
						busy <= 1'b0;
						store_done <= 1'b1;
					end
				end
			end
		end
	end

	a_no_rw: assert property (@(posedge clk) disable iff (rst) !(read && write));
endmodule

//--- src/reg_bank.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module reg_bank #(
	parameter type entry_t = lua_isa_pkg::word_t
) (
	input  logic                  clk,
	input  logic                  rst,
	input  lua_isa_pkg::reg_idx_t wr_idx,
	input  entry_t                wr_data,
	input  logic                  wr_en,
	input  lua_isa_pkg::reg_idx_t rd_idx_b,
	input  lua_isa_pkg::reg_idx_t rd_idx_c,
	output entry_t                rd_data_b,
	output entry_t                rd_data_c
);
	entry_t regs [`REG_CNT];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `REG_CNT; i++)
				regs[i] <= '0;	// nil / zero
		end else if (wr_en) begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign rd_data_b = regs[rd_idx_b];	// exec operand
	assign rd_data_c = regs[rd_idx_c];	// writeback
endmodule

//--- src/exec_sequencer.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module exec_sequencer (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    cmd_valid,
	input  cpu_ctrl_pkg::host_cmd_e cmd_kind,
	input  logic                    pc_done,
	input  logic                    ir_done,
	input  logic                    store_done,
	input  lua_isa_pkg::instr_t     instr,
	reg_write_if.sink               host_wr,
	input  lua_isa_pkg::word_t      rd_val_b,
	input  lua_isa_pkg::ttag_t      rd_tag_b,
	output logic                    fetch_pc,
	output logic                    fetch_instr,
	output logic                    store_pc,
	output logic                    store_regs,
	output lua_isa_pkg::reg_idx_t   rd_idx_b,
	output lua_isa_pkg::reg_idx_t   wr_idx,
	output lua_isa_pkg::word_t      wr_val,
	output lua_isa_pkg::ttag_t      wr_tag,
	output logic                    wr_val_en,
	output logic                    wr_tag_en,
	output logic                    done
);
	cpu_ctrl_pkg::ex_state_e state;
	logic                    is_move;
	logic                    move_wr;

	assign is_move = instr.op == lua_isa_pkg::op_move;
	assign move_wr = state == cpu_ctrl_pkg::exec && is_move;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= cpu_ctrl_pkg::idle;
		end else begin
			case (state)
				cpu_ctrl_pkg::idle: begin
					if (cmd_valid)
						state <= cmd_kind == cpu_ctrl_pkg::run ? cpu_ctrl_pkg::fetch_pc
							: cpu_ctrl_pkg::finish;	// loads already written
				end
				cpu_ctrl_pkg::fetch_pc: begin
					if (pc_done)
						state <= cpu_ctrl_pkg::fetch_instr;
				end
				cpu_ctrl_pkg::fetch_instr: begin
					if (ir_done)
						state <= cpu_ctrl_pkg::exec;
				end
				cpu_ctrl_pkg::exec: begin
					state <= is_move ? cpu_ctrl_pkg::fetch_instr : cpu_ctrl_pkg::store_pc;
				end
				cpu_ctrl_pkg::store_pc: begin
					if (pc_done)
						state <= cpu_ctrl_pkg::store_regs;
				end
				cpu_ctrl_pkg::store_regs: begin
					if (store_done)
						state <= cpu_ctrl_pkg::finish;
				end
				default: state <= cpu_ctrl_pkg::idle;
			endcase
		end
	end

	assign fetch_pc = state == cpu_ctrl_pkg::fetch_pc;
	assign fetch_instr = state == cpu_ctrl_pkg::fetch_instr;
	assign store_pc = state == cpu_ctrl_pkg::store_pc;
	assign store_regs = state == cpu_ctrl_pkg::store_regs;
	assign done = state == cpu_ctrl_pkg::finish;

	// R[A] <- R[B] with host loads on the same port
	assign rd_idx_b = instr.b[`REG_IDX_W-1:0];
	assign wr_idx = move_wr ? instr.a[`REG_IDX_W-1:0] : host_wr.idx;
	assign wr_val = move_wr ? rd_val_b : host_wr.data;
	assign wr_tag = move_wr ? rd_tag_b : host_wr.tag;
	assign wr_val_en = move_wr || host_wr.data_en;
	assign wr_tag_en = move_wr || host_wr.tag_en;

	a_host_idle: assert property (@(posedge clk) disable iff (rst)
		(host_wr.data_en || host_wr.tag_en) |-> state == cpu_ctrl_pkg::idle);
endmodule

//--- src/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetch_unit (
	input  logic                clk,
	input  logic                rst,
	input  lua_isa_pkg::word_t  ci,
	input  logic                fetch_pc,
	input  logic                fetch_instr,
	input  logic                store_pc,
	output logic                pc_done,
	output logic                ir_done,
	output lua_isa_pkg::instr_t instr,
	mem_if.requester            mem
);
	lua_isa_pkg::word_t pc;
	lua_isa_pkg::word_t savedpc_addr;
	logic               pc_rd;
	logic               pc_req;
	logic               ir_req;
	logic               xfer;

	assign savedpc_addr = ci + lua_isa_pkg::word_t'(`SAVEDPC_OFFSET);

	// request drops in the done cycle
	assign pc_rd = fetch_pc && !pc_done;
	assign pc_req = (fetch_pc || store_pc) && !pc_done;
	assign ir_req = fetch_instr && !ir_done;
	assign xfer = !mem.waitrequest;

	assign mem.address = pc_req ? savedpc_addr : pc;
	assign mem.writedata = pc;
	assign mem.read = pc_rd || ir_req;
	assign mem.write = store_pc && !pc_done;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pc <= '0;
			instr <= '0;
			pc_done <= 1'b0;
			ir_done <= 1'b0;
		end else begin
			pc_done <= pc_req && xfer;
			ir_done <= ir_req && xfer;
			if (pc_rd && xfer) begin
				pc <= mem.readdata;	// saved pc from frame
			end else if (ir_req && xfer) begin
				pc <= pc + lua_isa_pkg::word_t'(`PC_STEP);
				instr <= lua_isa_pkg::instr_t'(mem.readdata);
			end
		end
	end

	a_one_req: assert property (@(posedge clk) disable iff (rst) !(pc_req && ir_req));
endmodule

//--- src/host_cmd.sv
`timescale 1ns/1ps
`include "cpu_macros.svh"

module host_cmd (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	input  cpu_ctrl_pkg::host_cmd_e n,
	input  lua_isa_pkg::word_t     dataa,
	input  lua_isa_pkg::word_t     datab,
	output logic                   cmd_valid,
	output cpu_ctrl_pkg::host_cmd_e cmd_kind,
	output lua_isa_pkg::word_t     base,
	output lua_isa_pkg::word_t     ci,
	reg_write_if.source            wr
);
	lua_isa_pkg::word_t slot_idx;
	logic               in_range;

	assign slot_idx = (dataa - base) >> `TVALUE_SHIFT;	// byte offset to slot
	assign in_range = slot_idx < lua_isa_pkg::word_t'(`REG_CNT);

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			cmd_valid <= 1'b0;
			cmd_kind <= cpu_ctrl_pkg::run;
			base <= '0;
			ci <= '0;
			wr.data_en <= 1'b0;
			wr.tag_en <= 1'b0;
		end else begin
			cmd_valid <= start;
			wr.data_en <= start && n == cpu_ctrl_pkg::load_reg && in_range;
			wr.tag_en <= start && n == cpu_ctrl_pkg::load_tt && in_range;
			if (start) begin
				cmd_kind <= n;
				if (n == cpu_ctrl_pkg::run)
					ci <= datab;
				if (n == cpu_ctrl_pkg::load_base)
					base <= dataa;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			wr.idx <= slot_idx[`REG_IDX_W-1:0];
			wr.data <= datab;
			wr.tag <= datab[`TTAG_W-1:0];	// tag in low bits
		end
	end
endmodule

//--- src/cpu_ifs.sv
`timescale 1ns/1ps

interface mem_if;
	lua_isa_pkg::word_t address;
	lua_isa_pkg::word_t writedata;
	logic               read;
	logic               write;
	lua_isa_pkg::word_t readdata;
	logic               waitrequest;

	modport requester(output address, writedata, read, write, input readdata, waitrequest);
	modport responder(input address, writedata, read, write, output readdata, waitrequest);
endinterface

interface reg_write_if;
	lua_isa_pkg::reg_idx_t idx;
	lua_isa_pkg::word_t    data;
	lua_isa_pkg::ttag_t    tag;
	logic                  data_en;
	logic                  tag_en;

	modport source(output idx, data, tag, data_en, tag_en);
	modport sink(input idx, data, tag, data_en, tag_en);
endinterface

//--- src/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

	typedef enum logic [1:0] {
		run       = 2'd0,
		load_reg  = 2'd1,
		load_tt   = 2'd2,
		load_base = 2'd3
	} host_cmd_e;

	typedef enum logic [2:0] {
		idle, fetch_pc, fetch_instr, exec, store_pc, store_regs, finish
	} ex_state_e;

endpackage

//--- src/lua_isa_pkg.sv
`include "cpu_macros.svh"

package lua_isa_pkg;

	typedef logic [`WORD_W-1:0] word_t;
	typedef logic [`TTAG_W-1:0] ttag_t;
	typedef logic [`REG_IDX_W-1:0] reg_idx_t;

	// lua 5.3 opcode order
	typedef enum logic [5:0] {
		op_move, op_loadk, op_loadkx, op_loadbool, op_loadnil, op_getupval,
		op_gettabup, op_gettable, op_settabup, op_setupval, op_settable, op_newtable,
		op_self, op_add, op_sub, op_mul, op_mod, op_pow,
		op_div, op_idiv, op_band, op_bor, op_bxor, op_shl,
		op_shr, op_unm, op_bnot, op_not, op_len, op_concat,
		op_jmp, op_eq, op_lt, op_le, op_test, op_testset,
		op_call, op_tailcall, op_return, op_forloop, op_forprep, op_tforcall,
		op_tforloop, op_setlist, op_closure, op_vararg, op_extraarg
	} opcode_e;

	typedef struct packed {
		logic [8:0] hi;	// C or upper Bx bits
		logic [8:0] b;
		logic [7:0] a;
		opcode_e    op;
	} instr_t;

endpackage

//--- src/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH
`define WORD_W 32
`define TTAG_W 5
`define REG_CNT 32
`define REG_IDX_W 5
`define TVALUE_SHIFT 3
`define SAVEDPC_OFFSET 20
`define PC_STEP 4
`define TAG_OFFSET 4
`endif
